// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = amber_fetch_ctl_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/amber_fetch_ctl_asserts.sv ====
`default_nettype none

module amber_fetch_ctl_asserts import amber_pkg::*; (
    input logic  iw_clk,
    input logic  iw_rst,
    input logic  wb_cyc,
    input logic  wb_stb,
    input logic  wb_ack,
    input logic  redirect,
    input addr_t fetch_addr,
    input logic  fetch_valid,
    input logic  pcc_fault
);

    // Ack answers a request seen on the previous edge
    ack_after_req: assert property (@(posedge iw_clk) disable iff (iw_rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack raised without a preceding cyc and stb");

    ack_single: assert property (@(posedge iw_clk) disable iff (iw_rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles running");

    // A faulting PC stays put until a redirect moves it
    fault_holds_pc: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (pcc_fault && !redirect) |=> $stable(fetch_addr))
        else $error("fetch_addr moved while pcc_fault was high");

    // A valid fetch advances the PC by one
    valid_advances_pc: assert property (@(posedge iw_clk) disable iff (iw_rst)
        fetch_valid |=> (fetch_addr == $past(fetch_addr) + addr_t'(1)))
        else $error("fetch_addr did not advance after a valid fetch");

endmodule

`default_nettype wire

// ==== bench/amber_fetch_ctl_tb.sv ====
`default_nettype none

`include "amber_params.svh"

module amber_fetch_ctl_tb import amber_pkg::*; ();
    localparam int TEST_COUNT   = 5;
    localparam int CYCLE_BUDGET = 200;
    localparam int ACK_LIMIT    = 16;
    localparam int DW           = `AMBER_DATA_W;

    logic     iw_clk;
    logic     iw_rst;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    csr_idx_t wb_adr;
    data_t    wb_dat_w;
    data_t    wb_dat_r;
    logic     wb_ack;
    logic     stall;
    logic     redirect;
    addr_t    redirect_pc;
    logic     syscall;
    logic     kret;
    addr_t    fetch_addr;
    logic     fetch_valid;
    logic     pcc_fault;
    logic     mode_kernel;

    string       test_name;
    int          errors;
    int          checks;
    int          tests_failed;
    int          test_errors0;
    logic [31:0] rand_state = 32'h872;

    amber_fetch_ctl i_amber_fetch_ctl (.*);

    bind amber_fetch_ctl amber_fetch_ctl_asserts i_amber_fetch_ctl_asserts (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_ack      (wb_ack),
        .redirect    (redirect),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .pcc_fault   (pcc_fault)
    );

    initial begin
        iw_clk = 1'b0;
        forever #10 iw_clk = ~iw_clk;
    end

    initial begin
        repeat (TEST_COUNT * CYCLE_BUDGET) @(posedge iw_clk);
        $display("Timeout: no result after %0d cycles", TEST_COUNT * CYCLE_BUDGET);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic data_t next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state[31:8];
    endfunction

    task automatic compare(input string what, input addr_t expected, input addr_t actual);
        checks++;
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // One classic cycle, master holds everything until ack
    task automatic bus_transfer(input logic we, input csr_idx_t adr, input data_t wdat,
                                output data_t rdat);
        int waited;
        waited = 0;
        rdat = '0;
        @(posedge iw_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        @(negedge iw_clk);
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge iw_clk);
            waited++;
        end
        if (wb_ack) begin
            rdat = wb_dat_r;
        end else begin
            $display("%s: CSR index 0x%02h was never acknowledged", test_name, adr);
            errors++;
        end
        @(posedge iw_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input csr_idx_t adr, input data_t dat);
        data_t unused;
        bus_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input csr_idx_t adr, output data_t dat);
        bus_transfer(1'b0, adr, '0, dat);
    endtask

    task automatic redirect_to(input addr_t target);
        @(posedge iw_clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge iw_clk);
        redirect <= 1'b0;
        @(negedge iw_clk);
    endtask

    task automatic pulse_mode(input logic enter);
        @(posedge iw_clk);
        if (enter) begin
            syscall <= 1'b1;
        end else begin
            kret <= 1'b1;
        end
        @(posedge iw_clk);
        syscall <= 1'b0;
        kret    <= 1'b0;
        @(negedge iw_clk);
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_errors0 = errors;
    endtask

    task automatic report_test();
        if (errors == test_errors0) begin
            $display("[PASS] %s", test_name);
        end else begin
            $display("[DONE] %s with %0d errors", test_name, errors - test_errors0);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic reset_defaults();
        data_t rdat;
        start_test("reset_defaults");
        wb_read(`CSR_IDX_STATUS, rdat);
        compare("STATUS", addr_t'(1), addr_t'(rdat));
        wb_read(`CSR_IDX_PCC_LEN_LO, rdat);
        compare("LEN_LO", addr_t'(`PCC_LEN_RESET), addr_t'(rdat));
        wb_read(`CSR_IDX_PCC_PERMS, rdat);
        compare("PERMS", addr_t'(`PCC_PERMS_RESET), addr_t'(rdat));
        wb_read(`CSR_IDX_PCC_TAG, rdat);
        compare("TAG", addr_t'(1), addr_t'(rdat));
        @(negedge iw_clk);
        compare("fetch_addr above 0", addr_t'(1), addr_t'(fetch_addr != '0));
        compare("pcc_fault", addr_t'(0), addr_t'(pcc_fault));
        report_test();
    endtask

    task automatic csr_round_trip();
        csr_idx_t regs [5];
        data_t    vals [5];
        data_t    rdat;
        start_test("csr_round_trip");
        regs = '{`CSR_IDX_PCC_BASE_LO, `CSR_IDX_PCC_BASE_HI, `CSR_IDX_PCC_LEN_LO,
                 `CSR_IDX_PCC_LEN_HI, `CSR_IDX_PCC_ATTR};
        for (int i = 0; i < 5; i++) begin
            vals[i] = next_rand();
            wb_write(regs[i], vals[i]);
        end
        for (int i = 0; i < 5; i++) begin
            wb_read(regs[i], rdat);
            compare($sformatf("index 0x%02h", regs[i]), addr_t'(vals[i]), addr_t'(rdat));
        end
        wb_read(8'h40, rdat);
        compare("unmapped 0x40", addr_t'(0), addr_t'(rdat));
        report_test();
    endtask

    task automatic bounds_gating();
        addr_t prev;
        logic  settled;
        start_test("bounds_gating");
        wb_write(`CSR_IDX_PCC_BASE_LO, '0);
        wb_write(`CSR_IDX_PCC_BASE_HI, '0);
        wb_write(`CSR_IDX_PCC_LEN_HI, '0);
        wb_write(`CSR_IDX_PCC_LEN_LO, data_t'(16));
        redirect_to('0);
        prev = fetch_addr;
        settled = 1'b0;
        for (int i = 0; i < 64 && !settled; i++) begin
            @(negedge iw_clk);
            settled = (fetch_addr == prev);
            prev = fetch_addr;
        end
        if (!settled) begin
            $display("%s: fetch_addr kept changing past the window end", test_name);
            errors++;
        end
        compare("stop address", addr_t'(16), fetch_addr);
        compare("pcc_fault at end", addr_t'(1), addr_t'(pcc_fault));
        compare("fetch_valid at end", addr_t'(0), addr_t'(fetch_valid));
        redirect_to(addr_t'(4));
        compare("redirect address", addr_t'(4), fetch_addr);
        compare("pcc_fault after redirect", addr_t'(0), addr_t'(pcc_fault));
        // Hold the PC inside the window while the capability is changed
        @(posedge iw_clk);
        stall <= 1'b1;
        wb_write(`CSR_IDX_PCC_TAG, '0);
        @(negedge iw_clk);
        compare("pcc_fault tag clear", addr_t'(1), addr_t'(pcc_fault));
        wb_write(`CSR_IDX_PCC_TAG, data_t'(1));
        @(negedge iw_clk);
        compare("pcc_fault tag set", addr_t'(0), addr_t'(pcc_fault));
        wb_write(`CSR_IDX_PCC_PERMS, '0);
        @(negedge iw_clk);
        compare("pcc_fault no execute", addr_t'(1), addr_t'(pcc_fault));
        wb_write(`CSR_IDX_PCC_PERMS, data_t'(`PCC_PERMS_RESET));
        @(negedge iw_clk);
        compare("pcc_fault execute", addr_t'(0), addr_t'(pcc_fault));
        @(posedge iw_clk);
        stall <= 1'b0;
        report_test();
    endtask

    task automatic privilege_switch();
        data_t rdat;
        start_test("privilege_switch");
        wb_write(`CSR_IDX_STATUS, '0);
        @(negedge iw_clk);
        compare("mode_kernel after STATUS 0", addr_t'(0), addr_t'(mode_kernel));
        wb_write(`CSR_IDX_PCC_LEN_LO, next_rand());
        wb_read(`CSR_IDX_PCC_LEN_LO, rdat);
        compare("LEN_LO user write", addr_t'(16), addr_t'(rdat));
        wb_write(`CSR_IDX_STATUS, data_t'(1));
        wb_read(`CSR_IDX_STATUS, rdat);
        compare("STATUS user write", addr_t'(0), addr_t'(rdat));
        pulse_mode(1'b1);
        compare("mode_kernel after syscall", addr_t'(1), addr_t'(mode_kernel));
        pulse_mode(1'b0);
        compare("mode_kernel after kret", addr_t'(0), addr_t'(mode_kernel));
        report_test();
    endtask

    task automatic stall_and_cursor();
        addr_t target;
        data_t rdat;
        start_test("stall_and_cursor");
        target = {next_rand(), next_rand()};
        // Move the window onto the target so only stall can hold the PC
        pulse_mode(1'b1);
        wb_write(`CSR_IDX_PCC_BASE_LO, target[DW-1:0]);
        wb_write(`CSR_IDX_PCC_BASE_HI, target[`AMBER_ADDR_W-1:DW]);
        @(posedge iw_clk);
        stall <= 1'b1;
        redirect_to(target);
        for (int i = 0; i < 5; i++) begin
            @(negedge iw_clk);
            compare("held fetch_addr", target, fetch_addr);
            compare("fetch_valid in stall", addr_t'(0), addr_t'(fetch_valid));
            compare("pcc_fault in stall", addr_t'(0), addr_t'(pcc_fault));
        end
        wb_read(`CSR_IDX_PCC_CUR_LO, rdat);
        compare("CUR_LO", addr_t'(target[DW-1:0]), addr_t'(rdat));
        wb_read(`CSR_IDX_PCC_CUR_HI, rdat);
        compare("CUR_HI", addr_t'(target[`AMBER_ADDR_W-1:DW]), addr_t'(rdat));
        @(posedge iw_clk);
        stall <= 1'b0;
        report_test();
    endtask

    initial begin
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        syscall     = 1'b0;
        kret        = 1'b0;
        iw_rst      = 1'b1;
        repeat (2) @(posedge iw_clk);
        iw_rst <= 1'b0;

        reset_defaults();
        csr_round_trip();
        bounds_gating();
        privilege_switch();
        stall_and_cursor();

        $display("Tests run %0d, failed %0d; checks %0d, errors %0d",
                 TEST_COUNT, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/amber_pkg.sv
logic/pcc_csr_block.sv
logic/fetch_pc_seq.sv
logic/amber_fetch_ctl.sv
bench/amber_fetch_ctl_asserts.sv
bench/amber_fetch_ctl_tb.sv

// ==== logic/amber_fetch_ctl.sv ====
`default_nettype none

module amber_fetch_ctl import amber_pkg::*; (
    input  logic     iw_clk,
    input  logic     iw_rst,
    // Wishbone classic slave, CSR window
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  csr_idx_t wb_adr,
    input  data_t    wb_dat_w,
    output data_t    wb_dat_r,
    output logic     wb_ack,
    // Fetch control
    input  logic     stall,
    input  logic     redirect,
    input  addr_t    redirect_pc,
    input  logic     syscall,
    input  logic     kret,
    output addr_t    fetch_addr,
    output logic     fetch_valid,
    output logic     pcc_fault,
    output logic     mode_kernel
);
    addr_t pcc_base;
    addr_t pcc_len;
    data_t pcc_perms;
    logic  pcc_tag;

    // ------------------------------------------------------------
    // CSR window and privilege state
    // ------------------------------------------------------------
    pcc_csr_block i_pcc_csr_block (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .syscall     (syscall),
        .kret        (kret),
        .pc          (fetch_addr),
        .pcc_base    (pcc_base),
        .pcc_len     (pcc_len),
        .pcc_perms   (pcc_perms),
        .pcc_tag     (pcc_tag),
        .mode_kernel (mode_kernel)
    );

    // ------------------------------------------------------------
    // PC sequencer
    // ------------------------------------------------------------
    fetch_pc_seq i_fetch_pc_seq (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pcc_base    (pcc_base),
        .pcc_len     (pcc_len),
        .pcc_perms   (pcc_perms),
        .pcc_tag     (pcc_tag),
        .pc          (fetch_addr),
        .fetch_valid (fetch_valid),
        .pcc_fault   (pcc_fault)
    );

endmodule

`default_nettype wire

// ==== logic/amber_params.svh ====
`ifndef AMBER_PARAMS_SVH
`define AMBER_PARAMS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define AMBER_ADDR_W     48
`define AMBER_DATA_W     24
`define AMBER_CSR_IDX_W  8

// ------------------------------------------------------------
// CSR window index map
// ------------------------------------------------------------
`define CSR_IDX_STATUS       8'h00
`define CSR_IDX_PCC_BASE_LO  8'h10
`define CSR_IDX_PCC_BASE_HI  8'h11
`define CSR_IDX_PCC_LEN_LO   8'h12
`define CSR_IDX_PCC_LEN_HI   8'h13
// Cursor halves read back the live PC
`define CSR_IDX_PCC_CUR_LO   8'h14
`define CSR_IDX_PCC_CUR_HI   8'h15
`define CSR_IDX_PCC_PERMS    8'h16
`define CSR_IDX_PCC_ATTR     8'h17
`define CSR_IDX_PCC_TAG      8'h18

// ------------------------------------------------------------
// PCC permissions and reset state
// ------------------------------------------------------------
// Execute permission
`define PCC_PERM_X_BIT   2

// Default window is 4K starting at address 0, execute only
`define PCC_LEN_RESET    4096
`define PCC_PERMS_RESET  4

`endif

// ==== logic/amber_pkg.sv ====
`default_nettype none

`include "amber_params.svh"

// ------------------------------------------------------------
// Shared types for the fetch-address control
// ------------------------------------------------------------
package amber_pkg;

    // Fetch address, two CSR words wide
    typedef logic [`AMBER_ADDR_W-1:0] addr_t;

    // One CSR word
    typedef logic [`AMBER_DATA_W-1:0] data_t;

    // Index into the CSR window
    typedef logic [`AMBER_CSR_IDX_W-1:0] csr_idx_t;

endpackage

`default_nettype wire

// ==== logic/fetch_pc_seq.sv ====
`default_nettype none

`include "amber_params.svh"

module fetch_pc_seq import amber_pkg::*; (
    input  logic  iw_clk,
    input  logic  iw_rst,
    input  logic  stall,
    input  logic  redirect,
    input  addr_t redirect_pc,
    // Program counter capability
    input  addr_t pcc_base,
    input  addr_t pcc_len,
    input  data_t pcc_perms,
    input  logic  pcc_tag,
    output addr_t pc,
    output logic  fetch_valid,
    output logic  pcc_fault
);
    localparam int AW = `AMBER_ADDR_W;

    // One extra bit so base + length cannot wrap
    logic [AW:0] pcc_end;
    logic        in_bounds;
    logic        pcc_ok;

    // ------------------------------------------------------------
    // Capability check on the current PC
    // ------------------------------------------------------------
    assign pcc_end   = {1'b0, pcc_base} + {1'b0, pcc_len};
    assign in_bounds = (pc >= pcc_base) && ({1'b0, pc} < pcc_end);
    assign pcc_ok    = pcc_tag && pcc_perms[`PCC_PERM_X_BIT] && in_bounds;

    assign pcc_fault   = !pcc_ok;
    assign fetch_valid = pcc_ok && !stall && !redirect;

    // ------------------------------------------------------------
    // PC register
    // ------------------------------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall && pcc_ok) begin
            pc <= pc + addr_t'(1);
        end
        // Stall or capability violation holds the PC
    end

endmodule

`default_nettype wire

// ==== logic/pcc_csr_block.sv ====
`default_nettype none

`include "amber_params.svh"

module pcc_csr_block import amber_pkg::*; (
    input  logic     iw_clk,
    input  logic     iw_rst,
    // Wishbone classic slave
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  csr_idx_t wb_adr,
    input  data_t    wb_dat_w,
    output data_t    wb_dat_r,
    output logic     wb_ack,
    // Trap entry and return
    input  logic     syscall,
    input  logic     kret,
    // Live PC for cursor reads
    input  addr_t    pc,
    output addr_t    pcc_base,
    output addr_t    pcc_len,
    output data_t    pcc_perms,
    output logic     pcc_tag,
    output logic     mode_kernel
);
    localparam int DW = `AMBER_DATA_W;
    localparam int AW = `AMBER_ADDR_W;

    data_t pcc_attr;
    logic  wb_req;
    logic  wr_en;
    data_t rd_data;

    // New transfer on the bus; ack closes it on the next edge
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    // User mode writes are acked and dropped
    assign wr_en = wb_req && wb_we && mode_kernel;

    // ------------------------------------------------------------
    // Bus handshake
    // ------------------------------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // ------------------------------------------------------------
    // PCC fields
    // ------------------------------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pcc_base  <= '0;
            pcc_len   <= addr_t'(`PCC_LEN_RESET);
            pcc_perms <= data_t'(`PCC_PERMS_RESET);
            pcc_attr  <= '0;
            pcc_tag   <= 1'b1;
        end else if (wr_en) begin
            case (wb_adr)
                `CSR_IDX_PCC_BASE_LO: pcc_base[DW-1:0]  <= wb_dat_w;
                `CSR_IDX_PCC_BASE_HI: pcc_base[AW-1:DW] <= wb_dat_w;
                `CSR_IDX_PCC_LEN_LO:  pcc_len[DW-1:0]   <= wb_dat_w;
                `CSR_IDX_PCC_LEN_HI:  pcc_len[AW-1:DW]  <= wb_dat_w;
                `CSR_IDX_PCC_PERMS:   pcc_perms         <= wb_dat_w;
                // Attribute is held for software only
                `CSR_IDX_PCC_ATTR:    pcc_attr          <= wb_dat_w;
                `CSR_IDX_PCC_TAG:     pcc_tag           <= wb_dat_w[0];
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Privilege mode, 1 = kernel
    // ------------------------------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            mode_kernel <= 1'b1;
        end else if (syscall) begin
            mode_kernel <= 1'b1;
        end else if (kret) begin
            mode_kernel <= 1'b0;
        end else if (wr_en && (wb_adr == `CSR_IDX_STATUS)) begin
            mode_kernel <= wb_dat_w[0];
        end
    end

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            `CSR_IDX_STATUS:      rd_data = {{(DW-1){1'b0}}, mode_kernel};
            `CSR_IDX_PCC_BASE_LO: rd_data = pcc_base[DW-1:0];
            `CSR_IDX_PCC_BASE_HI: rd_data = pcc_base[AW-1:DW];
            `CSR_IDX_PCC_LEN_LO:  rd_data = pcc_len[DW-1:0];
            `CSR_IDX_PCC_LEN_HI:  rd_data = pcc_len[AW-1:DW];
            `CSR_IDX_PCC_CUR_LO:  rd_data = pc[DW-1:0];
            `CSR_IDX_PCC_CUR_HI:  rd_data = pc[AW-1:DW];
            `CSR_IDX_PCC_PERMS:   rd_data = pcc_perms;
            `CSR_IDX_PCC_ATTR:    rd_data = pcc_attr;
            `CSR_IDX_PCC_TAG:     rd_data = {{(DW-1){1'b0}}, pcc_tag};
            default:              rd_data = '0;
        endcase
    end

    // Captured on the request edge, valid with ack
    always_ff @(posedge iw_clk) begin
        if (wb_req && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire
